// ==== verilog/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// register numbers
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00c
`define CSR_SAVE0           14'h030
`define CSR_SAVE1           14'h031
`define CSR_SAVE2           14'h032
`define CSR_SAVE3           14'h033
`define CSR_TID             14'h040
`define CSR_TCFG            14'h041
`define CSR_TVAL            14'h042
`define CSR_TICLR           14'h044

// field positions
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2
`define CSR_ECFG_LIE        12:0
`define CSR_ESTAT_IS10      1:0
`define CSR_ESTAT_TI        11
`define CSR_EENTRY_VA       31:12
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_TICLR_CLR       0

// exception codes
`define ECODE_INT           6'h00
`define ECODE_ADEF          6'h08
`define ECODE_ALE           6'h09
`define ECODE_SYS           6'h0b
`define ECODE_BRK           6'h0c
`define ECODE_INE           6'h0d

// writable local interrupt enables, bit 10 is reserved
`define ECFG_WMASK          13'h1bff

`define TIMER_RESET_VAL     32'hffff_ffff

`endif

// ==== verilog/csr_types_pkg.sv ====
package csr_types_pkg;

    // csr number space
    typedef logic [13:0] csr_num_t;

    // register word, write mask or pc
    typedef logic [31:0] csr_word_t;

    typedef logic [1:0] plv_t;

    // ESTAT.is and ECFG.lie share one layout
    typedef logic [12:0] int_vec_t;

    // EENTRY bits 31:12
    typedef logic [19:0] eentry_va_t;

    // TCFG bits 31:2
    typedef logic [29:0] timer_init_t;

endpackage

// ==== verilog/csr_exc_pkg.sv ====
package csr_exc_pkg;

    // cause vector, msb first: int, adef, ale, brk, ine, sys
    // several bits may be set at once, priority is resolved on entry
    typedef logic [5:0] exc_vec_t;

    // ESTAT.ecode
    typedef logic [5:0] ecode_t;

endpackage

// ==== verilog/csr_except.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_except (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    input  csr_types_pkg::csr_word_t wb_pc,
    input  csr_types_pkg::csr_word_t wb_fault_vaddr,
    input  csr_exc_pkg::exc_vec_t    exc,
    input  logic                    ertn_flush,
    output logic                    crmd_ie,
    output csr_types_pkg::plv_t      crmd_plv,
    output csr_types_pkg::plv_t      prmd_pplv,
    output logic                    prmd_pie,
    output csr_exc_pkg::ecode_t      estat_ecode,
    output csr_types_pkg::csr_word_t era,
    output csr_types_pkg::csr_word_t badv,
    output csr_types_pkg::csr_word_t eentry
);
    import csr_types_pkg::*;
    import csr_exc_pkg::*;

    logic       exc_int, exc_adef, exc_ale, exc_brk, exc_ine, exc_sys;
    logic       wb_ex;
    ecode_t     wb_ecode;
    csr_word_t  wr_bits;
    eentry_va_t eentry_va;

    assign {exc_int, exc_adef, exc_ale, exc_brk, exc_ine, exc_sys} = exc;
    assign wb_ex   = |exc;
    assign wr_bits = csr_wr_value & csr_wr_mask;

    // int > adef > ine > sys > brk > ale
    always_comb begin
        if (exc_int)
            wb_ecode = `ECODE_INT;
        else if (exc_adef)
            wb_ecode = `ECODE_ADEF;
        else if (exc_ine)
            wb_ecode = `ECODE_INE;
        else if (exc_sys)
            wb_ecode = `ECODE_SYS;
        else if (exc_brk)
            wb_ecode = `ECODE_BRK;
        else
            wb_ecode = `ECODE_ALE;
    end

    // CRMD
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_wr_num == `CSR_CRMD) begin
            crmd_plv <= wr_bits[`CSR_CRMD_PLV] | (crmd_plv & ~csr_wr_mask[`CSR_CRMD_PLV]);
            crmd_ie  <= wr_bits[`CSR_CRMD_IE] | (crmd_ie & ~csr_wr_mask[`CSR_CRMD_IE]);
        end
    end

    // PRMD, ertn leaves it alone
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_wr_num == `CSR_PRMD) begin
            prmd_pplv <= wr_bits[`CSR_PRMD_PPLV] | (prmd_pplv & ~csr_wr_mask[`CSR_PRMD_PPLV]);
            prmd_pie  <= wr_bits[`CSR_PRMD_PIE] | (prmd_pie & ~csr_wr_mask[`CSR_PRMD_PIE]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            era <= '0;
        else if (wb_ex)
            era <= wb_pc;
        else if (csr_we && csr_wr_num == `CSR_ERA)
            era <= wr_bits | (era & ~csr_wr_mask);
    end

    // ecode and badv only hold meaning after an exception
    always_ff @(posedge clk) begin
        if (wb_ex)
            estat_ecode <= wb_ecode;
        if (wb_ex && (exc_adef || exc_ale))
            badv <= exc_adef ? wb_pc : wb_fault_vaddr;
        else if (!wb_ex && csr_we && csr_wr_num == `CSR_BADV)
            badv <= wr_bits | (badv & ~csr_wr_mask);
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            eentry_va <= '0;
        else if (csr_we && csr_wr_num == `CSR_EENTRY)
            eentry_va <= wr_bits[`CSR_EENTRY_VA] | (eentry_va & ~csr_wr_mask[`CSR_EENTRY_VA]);
    end

    // entry is 4KB aligned
    assign eentry = {eentry_va, 12'b0};

endmodule

// ==== verilog/csr_intr.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_intr (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    input  logic                    crmd_ie,
    input  logic                    timer_expire,
    output csr_types_pkg::int_vec_t  ecfg_lie,
    output csr_types_pkg::int_vec_t  estat_is,
    output logic                    has_int
);
    import csr_types_pkg::*;

    int_vec_t   lie_wmask;
    logic [1:0] sw_is;
    logic       timer_is;
    logic       ticlr_hit;

    // bits outside the writable set never change
    assign lie_wmask = csr_wr_mask[`CSR_ECFG_LIE] & `ECFG_WMASK;
    assign ticlr_hit = csr_we && csr_wr_num == `CSR_TICLR
                       && csr_wr_mask[`CSR_TICLR_CLR] && csr_wr_value[`CSR_TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!resetn)
            ecfg_lie <= '0;
        else if (csr_we && csr_wr_num == `CSR_ECFG)
            ecfg_lie <= (csr_wr_value[`CSR_ECFG_LIE] & lie_wmask) | (ecfg_lie & ~lie_wmask);
    end

    // software interrupts
    always_ff @(posedge clk) begin
        if (!resetn)
            sw_is <= '0;
        else if (csr_we && csr_wr_num == `CSR_ESTAT)
            sw_is <= (csr_wr_value[`CSR_ESTAT_IS10] & csr_wr_mask[`CSR_ESTAT_IS10])
                     | (sw_is & ~csr_wr_mask[`CSR_ESTAT_IS10]);
    end

    // timer pending, set wins over clear
    always_ff @(posedge clk) begin
        if (!resetn)
            timer_is <= 1'b0;
        else if (timer_expire)
            timer_is <= 1'b1;
        else if (ticlr_hit)
            timer_is <= 1'b0;
    end

    always_comb begin
        estat_is = '0;
        estat_is[`CSR_ESTAT_IS10] = sw_is;
        estat_is[`CSR_ESTAT_TI] = timer_is;
    end

    assign has_int = (|(estat_is & ecfg_lie)) & crmd_ie;

endmodule

// ==== verilog/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_timer (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    output csr_types_pkg::csr_word_t tid,
    output csr_types_pkg::csr_word_t tcfg,
    output csr_types_pkg::csr_word_t tval,
    output logic                    timer_expire
);
    import csr_types_pkg::*;

    logic        tcfg_wr;
    csr_word_t   tcfg_next;
    logic        tcfg_en;
    logic        tcfg_periodic;
    timer_init_t tcfg_initval;
    timer_init_t next_initval;
    csr_word_t   timer_cnt;

    assign tcfg_wr       = csr_we && csr_wr_num == `CSR_TCFG;
    // value TCFG takes at this edge if written
    assign tcfg_next     = (csr_wr_value & csr_wr_mask) | (tcfg & ~csr_wr_mask);
    assign tcfg_en       = tcfg[`CSR_TCFG_EN];
    assign tcfg_periodic = tcfg[`CSR_TCFG_PERIODIC];
    assign tcfg_initval  = tcfg[`CSR_TCFG_INITVAL];
    assign next_initval  = tcfg_next[`CSR_TCFG_INITVAL];

    always_ff @(posedge clk) begin
        if (!resetn)
            tid <= '0;
        else if (csr_we && csr_wr_num == `CSR_TID)
            tid <= (csr_wr_value & csr_wr_mask) | (tid & ~csr_wr_mask);
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            tcfg <= '0;
        else if (tcfg_wr)
            tcfg <= tcfg_next;
    end

    // counter parks at all ones in one-shot mode
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= `TIMER_RESET_VAL;
        end else if (tcfg_wr && tcfg_next[`CSR_TCFG_EN]) begin
            timer_cnt <= {next_initval, 2'b00};
        end else if (tcfg_en && timer_cnt != `TIMER_RESET_VAL) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 32'd1;
        end
    end

    assign tval         = timer_cnt;
    assign timer_expire = tcfg_en && timer_cnt == '0;

endmodule

// ==== verilog/csr_save.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_save (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    output csr_types_pkg::csr_word_t save0,
    output csr_types_pkg::csr_word_t save1,
    output csr_types_pkg::csr_word_t save2,
    output csr_types_pkg::csr_word_t save3
);
    import csr_types_pkg::*;

    csr_word_t save_q [4];

    // SAVE0..3 are consecutive numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!resetn)
                save_q[i] <= '0;
            else if (csr_we && csr_wr_num == `CSR_SAVE0 + 14'(i))
                save_q[i] <= (csr_wr_value & csr_wr_mask) | (save_q[i] & ~csr_wr_mask);
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== verilog/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux (
    input  logic                    csr_re,
    input  csr_types_pkg::csr_num_t  csr_rd_num,
    input  csr_types_pkg::plv_t      crmd_plv,
    input  csr_types_pkg::plv_t      prmd_pplv,
    input  logic                    crmd_ie,
    input  logic                    prmd_pie,
    input  csr_types_pkg::int_vec_t  ecfg_lie,
    input  csr_types_pkg::int_vec_t  estat_is,
    input  csr_exc_pkg::ecode_t      estat_ecode,
    input  csr_types_pkg::csr_word_t era,
    input  csr_types_pkg::csr_word_t badv,
    input  csr_types_pkg::csr_word_t eentry,
    input  csr_types_pkg::csr_word_t save0,
    input  csr_types_pkg::csr_word_t save1,
    input  csr_types_pkg::csr_word_t save2,
    input  csr_types_pkg::csr_word_t save3,
    input  csr_types_pkg::csr_word_t tid,
    input  csr_types_pkg::csr_word_t tcfg,
    input  csr_types_pkg::csr_word_t tval,
    output csr_types_pkg::csr_word_t csr_rd_value
);
    import csr_types_pkg::*;

    csr_word_t crmd_img;
    csr_word_t prmd_img;
    csr_word_t ecfg_img;
    csr_word_t estat_img;
    csr_word_t rd_sel;

    // da is bit 3, direct address mode only
    assign crmd_img  = {28'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_img  = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_img  = {19'b0, ecfg_lie};
    // esubcode is always zero
    assign estat_img = {10'b0, estat_ecode, 3'b0, estat_is};

    always_comb begin
        case (csr_rd_num)
            `CSR_CRMD:   rd_sel = crmd_img;
            `CSR_PRMD:   rd_sel = prmd_img;
            `CSR_ECFG:   rd_sel = ecfg_img;
            `CSR_ESTAT:  rd_sel = estat_img;
            `CSR_ERA:    rd_sel = era;
            `CSR_BADV:   rd_sel = badv;
            `CSR_EENTRY: rd_sel = eentry;
            `CSR_SAVE0:  rd_sel = save0;
            `CSR_SAVE1:  rd_sel = save1;
            `CSR_SAVE2:  rd_sel = save2;
            `CSR_SAVE3:  rd_sel = save3;
            `CSR_TID:    rd_sel = tid;
            `CSR_TCFG:   rd_sel = tcfg;
            `CSR_TVAL:   rd_sel = tval;
            // write-only clear register
            `CSR_TICLR:  rd_sel = '0;
            default:     rd_sel = '0;
        endcase
    end

    assign csr_rd_value = csr_re ? rd_sel : '0;

endmodule

// ==== verilog/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    csr_re,
    input  csr_types_pkg::csr_num_t  csr_rd_num,
    input  logic                    csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    input  csr_exc_pkg::exc_vec_t    exc,
    input  logic                    ertn_flush,
    input  csr_types_pkg::csr_word_t wb_pc,
    input  csr_types_pkg::csr_word_t wb_fault_vaddr,
    output csr_types_pkg::csr_word_t csr_rd_value,
    output csr_types_pkg::csr_word_t csr_eentry_pc,
    output csr_types_pkg::csr_word_t csr_eertn_pc,
    output logic                    has_int
);
    import csr_types_pkg::*;
    import csr_exc_pkg::*;

    logic      crmd_ie, prmd_pie, timer_expire;
    plv_t      crmd_plv, prmd_pplv;
    ecode_t    estat_ecode;
    int_vec_t  ecfg_lie, estat_is;
    csr_word_t era, badv, eentry;
    csr_word_t save0, save1, save2, save3;
    csr_word_t tid, tcfg, tval;

    csr_except u_except (
        .clk(clk), .resetn(resetn), .csr_we(csr_we), .csr_wr_num(csr_wr_num),
        .csr_wr_mask(csr_wr_mask), .csr_wr_value(csr_wr_value),
        .wb_pc(wb_pc), .wb_fault_vaddr(wb_fault_vaddr), .exc(exc), .ertn_flush(ertn_flush),
        .crmd_ie(crmd_ie), .crmd_plv(crmd_plv), .prmd_pplv(prmd_pplv), .prmd_pie(prmd_pie),
        .estat_ecode(estat_ecode), .era(era), .badv(badv), .eentry(eentry)
    );

    csr_intr u_intr (
        .clk(clk), .resetn(resetn), .csr_we(csr_we), .csr_wr_num(csr_wr_num),
        .csr_wr_mask(csr_wr_mask), .csr_wr_value(csr_wr_value),
        .crmd_ie(crmd_ie), .timer_expire(timer_expire),
        .ecfg_lie(ecfg_lie), .estat_is(estat_is), .has_int(has_int)
    );

    csr_timer u_timer (
        .clk(clk), .resetn(resetn), .csr_we(csr_we), .csr_wr_num(csr_wr_num),
        .csr_wr_mask(csr_wr_mask), .csr_wr_value(csr_wr_value),
        .tid(tid), .tcfg(tcfg), .tval(tval), .timer_expire(timer_expire)
    );

    csr_save u_save (
        .clk(clk), .resetn(resetn), .csr_we(csr_we), .csr_wr_num(csr_wr_num),
        .csr_wr_mask(csr_wr_mask), .csr_wr_value(csr_wr_value),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3)
    );

    csr_read_mux u_read_mux (
        .csr_re(csr_re), .csr_rd_num(csr_rd_num),
        .crmd_plv(crmd_plv), .prmd_pplv(prmd_pplv), .crmd_ie(crmd_ie), .prmd_pie(prmd_pie),
        .ecfg_lie(ecfg_lie), .estat_is(estat_is), .estat_ecode(estat_ecode),
        .era(era), .badv(badv), .eentry(eentry),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(tid), .tcfg(tcfg), .tval(tval), .csr_rd_value(csr_rd_value)
    );

    assign csr_eentry_pc = eentry;
    assign csr_eertn_pc  = era;

endmodule

// ==== test/csr_checker.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_checker (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     csr_re,
    input  csr_types_pkg::csr_num_t  csr_rd_num,
    input  logic                     csr_we,
    input  csr_types_pkg::csr_num_t  csr_wr_num,
    input  csr_types_pkg::csr_word_t csr_wr_mask,
    input  csr_types_pkg::csr_word_t csr_wr_value,
    input  csr_exc_pkg::exc_vec_t    exc,
    input  logic                     ertn_flush,
    input  csr_types_pkg::csr_word_t wb_pc,
    input  csr_types_pkg::csr_word_t wb_fault_vaddr,
    input  csr_types_pkg::csr_word_t csr_rd_value,
    input  csr_types_pkg::csr_word_t csr_eentry_pc,
    input  csr_types_pkg::csr_word_t csr_eertn_pc,
    input  logic                     has_int,
    input  logic                     done,
    input  int                       timeouts,
    output int                       err_count
);
    import csr_types_pkg::*;
    import csr_exc_pkg::*;

    // software-writable bits
    localparam csr_word_t crmd_wbits   = 32'h0000_0007;
    localparam csr_word_t prmd_wbits   = 32'h0000_0007;
    localparam csr_word_t estat_wbits  = 32'h0000_0003;
    localparam csr_word_t eentry_wbits = 32'hffff_f000;
    localparam csr_word_t ecfg_wbits   = {19'b0, `ECFG_WMASK};

    csr_word_t m_crmd, m_prmd, m_ecfg, m_estat_sw;
    csr_word_t m_era, m_badv, m_eentry;
    csr_word_t m_tid, m_tcfg, m_cnt;
    csr_word_t m_save [4];
    csr_word_t badv_care;
    ecode_t    m_ecode;
    logic      ecode_known;
    logic      m_ti;
    int        checks = 0;
    int        rd_errs = 0;
    int        pc_errs = 0;
    int        int_errs = 0;

    assign err_count = rd_errs + pc_errs + int_errs;

    function automatic csr_word_t merge_masked(csr_word_t old, csr_word_t nv, csr_word_t msk);
        return (nv & msk) | (old & ~msk);
    endfunction

    // exc bits from msb: int, adef, ale, brk, ine, sys
    function automatic ecode_t cause_code(exc_vec_t c);
        if (c[5])
            return `ECODE_INT;
        if (c[4])
            return `ECODE_ADEF;
        if (c[1])
            return `ECODE_INE;
        if (c[0])
            return `ECODE_SYS;
        if (c[2])
            return `ECODE_BRK;
        return `ECODE_ALE;
    endfunction

    function automatic csr_word_t read_image(csr_num_t num);
        case (num)
            `CSR_CRMD:   return m_crmd | 32'h0000_0008;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return {10'b0, m_ecode, 4'b0, m_ti, 9'b0, m_estat_sw[1:0]};
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0:  return m_save[0];
            `CSR_SAVE1:  return m_save[1];
            `CSR_SAVE2:  return m_save[2];
            `CSR_SAVE3:  return m_save[3];
            `CSR_TID:    return m_tid;
            `CSR_TCFG:   return m_tcfg;
            `CSR_TVAL:   return m_cnt;
            default:     return 32'h0;
        endcase
    endfunction

    // ecode and badv are unknown until an exception sets them
    function automatic csr_word_t read_care(csr_num_t num);
        if (num == `CSR_ESTAT && !ecode_known)
            return 32'hffc0_ffff;
        if (num == `CSR_BADV)
            return badv_care;
        return 32'hffff_ffff;
    endfunction

    task automatic reset_model();
        m_crmd = 32'h0;
        m_prmd = 32'h0;
        m_ecfg = 32'h0;
        m_estat_sw = 32'h0;
        m_era = 32'h0;
        m_eentry = 32'h0;
        m_tid = 32'h0;
        m_tcfg = 32'h0;
        m_cnt = 32'hffff_ffff;
        m_ti = 1'b0;
        for (int i = 0; i < 4; i++)
            m_save[i] = 32'h0;
        m_badv = 32'h0;
        badv_care = 32'h0;
        m_ecode = 6'h0;
        ecode_known = 1'b0;
    endtask

    task automatic compare_outputs();
        csr_word_t exp_rd;
        csr_word_t care;
        int_vec_t  is_vec;
        logic      exp_int;
        exp_rd = 32'h0;
        care = 32'hffff_ffff;
        if (csr_re) begin
            exp_rd = read_image(csr_rd_num);
            care = read_care(csr_rd_num);
        end
        is_vec = {1'b0, m_ti, 9'b0, m_estat_sw[1:0]};
        exp_int = (|(is_vec & m_ecfg[12:0])) & m_crmd[`CSR_CRMD_IE];
        checks++;
        if ((csr_rd_value & care) !== (exp_rd & care)) begin
            rd_errs++;
            $display("Fail at %0t: csr 0x%03h read 0x%08h, expected 0x%08h",
                     $time, csr_rd_num, csr_rd_value, exp_rd);
        end
        if (csr_eentry_pc !== m_eentry || csr_eertn_pc !== m_era) begin
            pc_errs++;
            $display("Fail at %0t: eentry_pc 0x%08h eertn_pc 0x%08h, expected 0x%08h 0x%08h",
                     $time, csr_eentry_pc, csr_eertn_pc, m_eentry, m_era);
        end
        if (has_int !== exp_int) begin
            int_errs++;
            $display("Fail at %0t: has_int is %b, expected %b", $time, has_int, exp_int);
        end
    endtask

    task automatic step_model();
        logic      ex;
        logic      wr;
        logic      expire;
        logic      ticlr;
        csr_word_t wm;
        csr_word_t wv;
        csr_word_t old_crmd;
        csr_word_t next_tcfg;
        ex = (exc != 6'b0);
        wr = csr_we;
        wm = csr_wr_mask;
        wv = csr_wr_value;
        old_crmd = m_crmd;
        expire = m_tcfg[`CSR_TCFG_EN] && m_cnt == 32'h0;
        ticlr = wr && csr_wr_num == `CSR_TICLR && wm[`CSR_TICLR_CLR] && wv[`CSR_TICLR_CLR];

        // prmd bits line up with crmd plv and ie
        if (ex)
            m_crmd = 32'h0;
        else if (ertn_flush)
            m_crmd = m_prmd;
        else if (wr && csr_wr_num == `CSR_CRMD)
            m_crmd = merge_masked(m_crmd, wv, wm & crmd_wbits);

        if (ex)
            m_prmd = old_crmd;
        else if (wr && csr_wr_num == `CSR_PRMD)
            m_prmd = merge_masked(m_prmd, wv, wm & prmd_wbits);

        if (ex) begin
            m_era = wb_pc;
            m_ecode = cause_code(exc);
            ecode_known = 1'b1;
            if (exc[4]) begin
                m_badv = wb_pc;
                badv_care = 32'hffff_ffff;
            end else if (exc[3]) begin
                m_badv = wb_fault_vaddr;
                badv_care = 32'hffff_ffff;
            end
        end else begin
            if (wr && csr_wr_num == `CSR_ERA)
                m_era = merge_masked(m_era, wv, wm);
            if (wr && csr_wr_num == `CSR_BADV) begin
                m_badv = merge_masked(m_badv, wv, wm);
                badv_care = badv_care | wm;
            end
        end

        if (wr) begin
            case (csr_wr_num)
                `CSR_ECFG:   m_ecfg = merge_masked(m_ecfg, wv, wm & ecfg_wbits);
                `CSR_ESTAT:  m_estat_sw = merge_masked(m_estat_sw, wv, wm & estat_wbits);
                `CSR_EENTRY: m_eentry = merge_masked(m_eentry, wv, wm & eentry_wbits);
                `CSR_SAVE0:  m_save[0] = merge_masked(m_save[0], wv, wm);
                `CSR_SAVE1:  m_save[1] = merge_masked(m_save[1], wv, wm);
                `CSR_SAVE2:  m_save[2] = merge_masked(m_save[2], wv, wm);
                `CSR_SAVE3:  m_save[3] = merge_masked(m_save[3], wv, wm);
                `CSR_TID:    m_tid = merge_masked(m_tid, wv, wm);
                default:     ;
            endcase
        end

        if (expire)
            m_ti = 1'b1;
        else if (ticlr)
            m_ti = 1'b0;

        // a write that enables the timer restarts the count
        next_tcfg = m_tcfg;
        if (wr && csr_wr_num == `CSR_TCFG)
            next_tcfg = merge_masked(m_tcfg, wv, wm);
        if (wr && csr_wr_num == `CSR_TCFG && next_tcfg[`CSR_TCFG_EN]) begin
            m_cnt = {next_tcfg[31:2], 2'b00};
        end else if (m_tcfg[`CSR_TCFG_EN] && m_cnt != 32'hffff_ffff) begin
            if (m_cnt != 32'h0)
                m_cnt = m_cnt - 32'd1;
            else if (m_tcfg[`CSR_TCFG_PERIODIC])
                m_cnt = {m_tcfg[31:2], 2'b00};
            else
                m_cnt = 32'hffff_ffff;
        end
        m_tcfg = next_tcfg;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            reset_model();
        end else begin
            compare_outputs();
            step_model();
        end
    end

    always @(posedge done) begin
        $display("checks %0d, read errors %0d, pc errors %0d, has_int errors %0d, timeouts %0d",
                 checks, rd_errs, pc_errs, int_errs, timeouts);
    end

endmodule

// ==== test/tb_csr.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr;
    import csr_types_pkg::*;
    import csr_exc_pkg::*;

    logic      clk;
    logic      resetn;
    logic      csr_re;
    csr_num_t  csr_rd_num;
    logic      csr_we;
    csr_num_t  csr_wr_num;
    csr_word_t csr_wr_mask;
    csr_word_t csr_wr_value;
    exc_vec_t  exc;
    logic      ertn_flush;
    csr_word_t wb_pc;
    csr_word_t wb_fault_vaddr;
    csr_word_t csr_rd_value;
    csr_word_t csr_eentry_pc;
    csr_word_t csr_eertn_pc;
    logic      has_int;

    logic [31:0] lfsr_q;
    logic        done;
    int          timeouts;
    int          err_count;

    csr_top DUT (
        .clk(clk), .resetn(resetn), .csr_re(csr_re), .csr_rd_num(csr_rd_num),
        .csr_we(csr_we), .csr_wr_num(csr_wr_num), .csr_wr_mask(csr_wr_mask),
        .csr_wr_value(csr_wr_value), .exc(exc), .ertn_flush(ertn_flush),
        .wb_pc(wb_pc), .wb_fault_vaddr(wb_fault_vaddr), .csr_rd_value(csr_rd_value),
        .csr_eentry_pc(csr_eentry_pc), .csr_eertn_pc(csr_eertn_pc), .has_int(has_int)
    );

    csr_checker chk (
        .clk(clk), .resetn(resetn), .csr_re(csr_re), .csr_rd_num(csr_rd_num),
        .csr_we(csr_we), .csr_wr_num(csr_wr_num), .csr_wr_mask(csr_wr_mask),
        .csr_wr_value(csr_wr_value), .exc(exc), .ertn_flush(ertn_flush),
        .wb_pc(wb_pc), .wb_fault_vaddr(wb_fault_vaddr), .csr_rd_value(csr_rd_value),
        .csr_eentry_pc(csr_eentry_pc), .csr_eertn_pc(csr_eertn_pc), .has_int(has_int),
        .done(done), .timeouts(timeouts), .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic csr_num_t pick_csr(logic [3:0] idx);
        case (idx)
            4'd0:    return `CSR_CRMD;
            4'd1:    return `CSR_PRMD;
            4'd2:    return `CSR_ECFG;
            4'd3:    return `CSR_ESTAT;
            4'd4:    return `CSR_ERA;
            4'd5:    return `CSR_BADV;
            4'd6:    return `CSR_EENTRY;
            4'd7:    return `CSR_SAVE0;
            4'd8:    return `CSR_SAVE1;
            4'd9:    return `CSR_SAVE2;
            4'd10:   return `CSR_SAVE3;
            4'd11:   return `CSR_TID;
            4'd12:   return `CSR_TCFG;
            4'd13:   return `CSR_TVAL;
            4'd14:   return `CSR_TICLR;
            // not a kept register
            default: return 14'h02a;
        endcase
    endfunction

    task automatic random_cycle();
        logic [31:0] r;
        logic [1:0]  full;
        @(negedge clk);
        take_bits(1, r);
        csr_we = r[0];
        take_bits(4, r);
        csr_wr_num = pick_csr(r[3:0]);
        take_bits(2, r);
        full = r[1:0];
        take_bits(32, r);
        csr_wr_mask = (full == 2'b00) ? 32'hffff_ffff : r;
        take_bits(32, r);
        csr_wr_value = r;
        if (csr_wr_num == `CSR_TCFG) begin
            // small initval so the count gets to zero
            take_bits(6, r);
            csr_wr_value = {26'b0, r[5:0]};
        end
        take_bits(3, r);
        csr_re = (r[2:0] != 3'b000);
        take_bits(4, r);
        csr_rd_num = pick_csr(r[3:0]);
        take_bits(4, r);
        exc = 6'b0;
        if (r[3:0] == 4'b0000) begin
            take_bits(3, r);
            if (r[2:0] < 3'd6) begin
                exc = 6'b000001 << r[2:0];
            end else begin
                take_bits(6, r);
                exc = r[5:0];
            end
        end
        take_bits(4, r);
        ertn_flush = (r[3:0] == 4'b0000);
        take_bits(32, r);
        wb_pc = r;
        take_bits(32, r);
        wb_fault_vaddr = r;
    endtask

    task automatic write_csr(input csr_num_t num, input csr_word_t mask, input csr_word_t value);
        @(negedge clk);
        csr_we = 1'b1;
        csr_wr_num = num;
        csr_wr_mask = mask;
        csr_wr_value = value;
        @(negedge clk);
        csr_we = 1'b0;
    endtask

    task automatic pulse_exc(input exc_vec_t cause, input logic ertn, input csr_word_t pc);
        @(negedge clk);
        exc = cause;
        ertn_flush = ertn;
        wb_pc = pc;
        wb_fault_vaddr = ~pc;
        @(negedge clk);
        exc = 6'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic wait_for_int(input int limit, input string what);
        int n;
        n = 0;
        while (!has_int && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!has_int) begin
            $display("timeout: %s did not raise has_int within %0d cycles", what, limit);
            timeouts++;
        end
    endtask

    initial begin
        lfsr_q = 32'd9;
        resetn = 1'b0;
        csr_re = 1'b0;
        csr_rd_num = 14'h0;
        csr_we = 1'b0;
        csr_wr_num = 14'h0;
        csr_wr_mask = 32'h0;
        csr_wr_value = 32'h0;
        exc = 6'b0;
        ertn_flush = 1'b0;
        wb_pc = 32'h0;
        wb_fault_vaddr = 32'h0;
        done = 1'b0;
        timeouts = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < 3000; i++)
            random_cycle();

        @(negedge clk);
        csr_we = 1'b0;
        exc = 6'b0;
        ertn_flush = 1'b0;
        csr_re = 1'b1;
        csr_rd_num = `CSR_CRMD;

        // exception and ertn together, then ertn alone
        write_csr(`CSR_CRMD, 32'h7, 32'h7);
        pulse_exc(6'b000001, 1'b1, 32'h1c00_0100);
        pulse_exc(6'b000000, 1'b1, 32'h1c00_0200);

        // one-shot timer, only the timer interrupt enabled
        csr_rd_num = `CSR_TVAL;
        write_csr(`CSR_CRMD, 32'h7, 32'h4);
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h800);
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0000_000d);
        wait_for_int(100, "one-shot timer");
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        repeat (20) @(negedge clk);

        // periodic timer reloads
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0000_000b);
        wait_for_int(100, "periodic timer");
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        wait_for_int(100, "periodic reload");
        write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
        write_csr(`CSR_TICLR, 32'h1, 32'h1);

        // software interrupt 0
        csr_rd_num = `CSR_ESTAT;
        write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h1);
        write_csr(`CSR_ESTAT, 32'h3, 32'h1);
        wait_for_int(10, "software interrupt");
        repeat (4) @(negedge clk);

        done = 1'b1;
        #1;
        if (err_count == 0 && timeouts == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/csr_types_pkg.sv
verilog/csr_exc_pkg.sv
verilog/csr_except.sv
verilog/csr_intr.sv
verilog/csr_timer.sv
verilog/csr_save.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
test/csr_checker.sv
test/tb_csr.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f filelist.f --top-module tb_csr -Mdir obj_dir -o sim_csr \
    && ./obj_dir/sim_csr > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
